// File: Bender.yml
package:
  name: pattern_source

sources:
  # Package first, then the blocks, then the top level.
  - files:
      - hdl/pattern_pkg.sv
      - hdl/size_shadow.sv
      - hdl/frame_scan.sv
      - hdl/tile_ram.sv
      - hdl/pattern_source_top.sv

  # Testbench, simulation only.
  - target: simulation
    files:
      - bench/tb_pattern_source.sv

# Top modules: pattern_source_top, tb_pattern_source.

// File: bench/tb_pattern_source.sv
`default_nettype none

module tb_pattern_source;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int X_BITS      = 8;
    localparam int Y_BITS      = 8;
    localparam int DATA_BITS   = 24;
    localparam int TILE_BITS   = 2;
    localparam int INIT_WIDTH  = 6;
    localparam int INIT_HEIGHT = 4;
    localparam int NEW_WIDTH   = 8;
    localparam int NEW_HEIGHT  = 6;

    localparam int ADDR_BITS  = 2 * TILE_BITS;
    localparam int TILE_SIDE  = 1 << TILE_BITS;
    localparam int TILE_WORDS = 1 << ADDR_BITS;
    localparam int CLK_PERIOD = 4;

    // Frames 1..7 at the initial size, frames 8..12 at the new one.
    localparam int TOTAL_BEATS  = 7 * INIT_WIDTH * INIT_HEIGHT + 5 * NEW_WIDTH * NEW_HEIGHT;
    localparam int SETUP_CYCLES = 8 + 2 * TILE_WORDS + 16;
    localparam int WATCHDOG_NS  = (TOTAL_BEATS + SETUP_CYCLES) * 4 * CLK_PERIOD;

    logic                   m_axi4s = 1'b0;
    logic                   rst_n;
    logic   [X_BITS-1:0]    cfg_width;
    logic   [Y_BITS-1:0]    cfg_height;
    logic                   cfg_load;
    logic                   cfg_pending;
    logic                   wr_en;
    logic   [ADDR_BITS-1:0] wr_addr;
    logic   [DATA_BITS-1:0] wr_data;
    logic   [DATA_BITS-1:0] m_axi4s_tdata;
    logic                   m_axi4s_tvalid;
    logic                   m_axi4s_tuser;
    logic                   m_axi4s_tlast;
    logic                   m_axi4s_tready;

    // Reference model state.
    logic   [TILE_WORDS-1:0][DATA_BITS-1:0] tile_model;
    logic   [TILE_WORDS-1:0][DATA_BITS-1:0] tile_next;    // Takes effect at the next frame.
    int     exp_x = 0;
    int     exp_y = 0;
    int     model_w = INIT_WIDTH;
    int     model_h = INIT_HEIGHT;
    int     pend_w;
    int     pend_h;
    bit     model_pending = 1'b0;
    bit     sof_pending_check = 1'b0;

    int     errors = 0;
    int     beats = 0;
    int     frames_done = 0;
    int     en_edges = 0;
    bit     seen_valid = 1'b0;
    bit     stalled = 1'b0;
    logic   [DATA_BITS+2:0] held_out;
    int     ready_mode;    // 0 high, 1 random, 2 low.
    integer seed;

    pattern_source_top #(
        .X_BITS         (X_BITS),
        .Y_BITS         (Y_BITS),
        .DATA_BITS      (DATA_BITS),
        .TILE_BITS      (TILE_BITS),
        .INIT_WIDTH     (INIT_WIDTH),
        .INIT_HEIGHT    (INIT_HEIGHT)
    ) UUT (
        .m_axi4s        (m_axi4s),
        .rst_n          (rst_n),
        .cfg_width      (cfg_width),
        .cfg_height     (cfg_height),
        .cfg_load       (cfg_load),
        .cfg_pending    (cfg_pending),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .m_axi4s_tdata  (m_axi4s_tdata),
        .m_axi4s_tvalid (m_axi4s_tvalid),
        .m_axi4s_tuser  (m_axi4s_tuser),
        .m_axi4s_tlast  (m_axi4s_tlast),
        .m_axi4s_tready (m_axi4s_tready)
    );

    always #(CLK_PERIOD / 2) m_axi4s = ~m_axi4s;

    // **************************************************
    //  Helpers
    // **************************************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Tile repeats across the frame, row major inside the tile.
    function automatic logic [DATA_BITS-1:0] expected_pixel(
        input logic [TILE_WORDS-1:0][DATA_BITS-1:0] tile, input int x, input int y);
        int col;
        int row;
        col = x % TILE_SIDE;
        row = y % TILE_SIDE;
        return tile[row * TILE_SIDE + col];
    endfunction

    function automatic logic [DATA_BITS-1:0] fill_word(input int addr, input int gen);
        logic [7:0] a8;
        a8 = 8'(addr);
        return {4'(gen), 4'(addr), a8 * 8'd29 + 8'd7, a8 ^ 8'hc3};
    endfunction

    // One clock, then drive tready a little after the edge.
    task automatic step_cycle();
        logic [31:0] rnd;
        @(posedge m_axi4s);
        #1;
        case (ready_mode)
            0:       m_axi4s_tready = 1'b1;
            1: begin
                rnd = $random(seed);
                m_axi4s_tready = (rnd[1:0] != 2'b00);
            end
            default: m_axi4s_tready = 1'b0;
        endcase
    endtask

    task automatic write_tile(input int addr, input logic [DATA_BITS-1:0] data);
        wr_en   = 1'b1;
        wr_addr = ADDR_BITS'(addr);
        wr_data = data;
        step_cycle();
        wr_en   = 1'b0;
    endtask

    // **************************************************
    //  Comparison process
    // **************************************************

    always @(posedge m_axi4s) begin
        if (!rst_n) begin
            check_value("m_axi4s_tvalid", m_axi4s_tvalid, 0);
            check_value("m_axi4s_tuser", m_axi4s_tuser, 0);
            check_value("m_axi4s_tlast", m_axi4s_tlast, 0);
            stalled = 1'b0;
        end else begin
            if (stalled && {m_axi4s_tdata, m_axi4s_tvalid, m_axi4s_tuser, m_axi4s_tlast}
                           !== held_out) begin
                $display("ERROR: stream output changed while tready was low at %0t", $time);
                errors++;
            end
            stalled  = m_axi4s_tvalid && !m_axi4s_tready;
            held_out = {m_axi4s_tdata, m_axi4s_tvalid, m_axi4s_tuser, m_axi4s_tlast};
            if (m_axi4s_tvalid && !seen_valid) begin
                check_value("enabled edges to first tvalid", en_edges,
                            pattern_pkg::READ_LATENCY + 1);
                seen_valid = 1'b1;
            end
            if (m_axi4s_tready) begin
                en_edges++;
            end
            if (m_axi4s_tvalid && m_axi4s_tready) begin
                if (sof_pending_check) begin
                    check_value("cfg_pending", cfg_pending, 0);    // Cleared at the wrap.
                    sof_pending_check = 1'b0;
                end
                check_value("m_axi4s_tdata", m_axi4s_tdata,
                            expected_pixel(tile_model, exp_x, exp_y));
                check_value("m_axi4s_tuser", m_axi4s_tuser, (exp_x == 0) && (exp_y == 0));
                check_value("m_axi4s_tlast", m_axi4s_tlast, exp_x == model_w - 1);
                beats++;
                if (exp_x == model_w - 1) begin
                    exp_x = 0;
                    if (exp_y == model_h - 1) begin
                        exp_y = 0;
                        frames_done++;
                        tile_model = tile_next;
                        if (model_pending) begin
                            model_w = pend_w;
                            model_h = pend_h;
                            model_pending = 1'b0;
                            sof_pending_check = 1'b1;
                        end
                    end else begin
                        exp_y++;
                    end
                end else begin
                    exp_x++;
                end
            end
        end
    end

    // **************************************************
    //  Stimulus
    // **************************************************

    initial begin
        int skip_row;
        logic [DATA_BITS-1:0] word;
        seed           = 32'h2e44_1289;
        rst_n          = 1'b1;
        ready_mode     = 2;
        m_axi4s_tready = 1'b0;
        cfg_width      = X_BITS'(INIT_WIDTH);
        cfg_height     = Y_BITS'(INIT_HEIGHT);
        cfg_load       = 1'b0;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        #1;
        rst_n = 1'b0;
        repeat (8) step_cycle();
        rst_n = 1'b1;
        check_value("cfg_pending", cfg_pending, 0);

        // Tile filled while the stream is held off.
        for (int a = 0; a < TILE_WORDS; a++) begin
            word = fill_word(a, 1);
            tile_next[a] = word;
            write_tile(a, word);
        end
        tile_model = tile_next;

        ready_mode = 0;
        while (frames_done < 3) step_cycle();
        ready_mode = 1;
        while (frames_done < 6) step_cycle();

        // Size change requested in the middle of frame 7.
        while (exp_y != 1) step_cycle();
        cfg_width     = X_BITS'(NEW_WIDTH);
        cfg_height    = Y_BITS'(NEW_HEIGHT);
        cfg_load      = 1'b1;
        pend_w        = NEW_WIDTH;
        pend_h        = NEW_HEIGHT;
        model_pending = 1'b1;
        step_cycle();
        cfg_load = 1'b0;
        check_value("cfg_pending", cfg_pending, 1);

        // Tile rewrite in the last row of frame 10. Scanner is frozen meanwhile.
        while (frames_done < 9) step_cycle();
        while (!(exp_y == model_h - 1 && exp_x >= 1)) step_cycle();
        ready_mode     = 2;
        m_axi4s_tready = 1'b0;
        skip_row       = (model_h - 1) % TILE_SIDE;    // Row still being read.
        for (int a = 0; a < TILE_WORDS; a++) begin
            if (a / TILE_SIDE != skip_row) begin
                word = fill_word(a, 2);
                tile_next[a] = word;
                write_tile(a, word);
            end
        end
        ready_mode = 1;
        while (frames_done < 12) step_cycle();

        $display("Errors: %0d, beats checked: %0d, frames: %0d", errors, beats, frames_done);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: timeout, only %0d of %0d beats arrived", beats, TOTAL_BEATS);
        $display("Errors: %0d, beats checked: %0d, frames: %0d", errors + 1, beats,
                 frames_done);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/frame_scan.sv
`default_nettype none

module frame_scan #(
    parameter   int     X_BITS = pattern_pkg::X_BITS_DEFAULT,
    parameter   int     Y_BITS = pattern_pkg::Y_BITS_DEFAULT
) (
    input   var logic                   m_axi4s         ,
    input   var logic                   rst_n           ,
    input   var logic                   m_axi4s_tready  ,
    input   var logic   [X_BITS-1:0]    active_width    ,
    input   var logic   [Y_BITS-1:0]    active_height   ,

    output  var logic                   rd_en           ,
    output  var logic   [X_BITS-1:0]    rd_x            ,
    output  var logic   [Y_BITS-1:0]    rd_y            ,
    output  var logic                   frame_wrap      ,

    output  var logic                   m_axi4s_tvalid  ,
    output  var logic                   m_axi4s_tuser   ,
    output  var logic                   m_axi4s_tlast
);

    localparam  int     LAT = pattern_pkg::READ_LATENCY;

    // **************************************************
    //  Stage 0: raster counter
    // **************************************************

    logic   [X_BITS-1:0]    st0_x;
    logic   [Y_BITS-1:0]    st0_y;
    logic                   st0_valid;

    logic   [X_BITS-1:0]    last_x;
    logic   [Y_BITS-1:0]    last_y;
    logic                   end_of_line;
    logic                   end_of_frame;

    assign last_x       = active_width - X_BITS'(1);
    assign last_y       = active_height - Y_BITS'(1);
    assign end_of_line  = (st0_x == last_x);
    assign end_of_frame = end_of_line && (st0_y == last_y);

    // Counter holds at (0,0) until stage 0 turns valid, so pixel (0,0) is the first beat.
    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            st0_x     <= '0;
            st0_y     <= '0;
            st0_valid <= 1'b0;
        end else if (m_axi4s_tready) begin
            st0_valid <= 1'b1;
            if (st0_valid) begin
                if (end_of_line) begin
                    st0_x <= '0;
                    if (end_of_frame) begin
                        st0_y <= '0;
                    end else begin
                        st0_y <= st0_y + 1'b1;
                    end
                end else begin
                    st0_x <= st0_x + 1'b1;
                end
            end
        end
    end

    // Size shadow swaps the active size on this edge.
    assign frame_wrap = m_axi4s_tready && st0_valid && end_of_frame;

    // Memory read port follows the scanner.
    assign rd_en = m_axi4s_tready;
    assign rd_x  = st0_x;
    assign rd_y  = st0_y;

    // **************************************************
    //  Stages 1..LAT: flag delay line
    // **************************************************

    // Index 0 is stage 1, index LAT-1 meets the memory data.
    logic   [LAT-1:0]       dl_valid;
    logic   [LAT-1:0]       dl_tuser;
    logic   [LAT-1:0]       dl_tlast;

    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            dl_valid <= '0;
            dl_tuser <= '0;
            dl_tlast <= '0;
        end else if (m_axi4s_tready) begin
            dl_valid[0] <= st0_valid;
            dl_tuser[0] <= (st0_x == '0) && (st0_y == '0);    // Start of frame.
            dl_tlast[0] <= end_of_line;                        // End of line.
            for (int i = 1; i < LAT; i++) begin
                dl_valid[i] <= dl_valid[i-1];
                dl_tuser[i] <= dl_tuser[i-1];
                dl_tlast[i] <= dl_tlast[i-1];
            end
        end
    end

    assign m_axi4s_tvalid = dl_valid[LAT-1];
    assign m_axi4s_tuser  = dl_tuser[LAT-1];
    assign m_axi4s_tlast  = dl_tlast[LAT-1];

endmodule

`default_nettype wire

// File: hdl/pattern_pkg.sv
`default_nettype none

package pattern_pkg;

    // **************************************************
    //  Default geometry
    // **************************************************

    // Horizontal coordinate and frame width.
    localparam  int     X_BITS_DEFAULT    = 14;

    // Vertical coordinate and frame height.
    localparam  int     Y_BITS_DEFAULT    = 14;

    // RGB888 pixel.
    localparam  int     DATA_BITS_DEFAULT = 24;

    // log2 of the tile side, 16 x 16 pixels.
    localparam  int     TILE_BITS_DEFAULT = 4;

    // **************************************************
    //  Tile memory read path
    // **************************************************

    // Enabled clock cycles from read address to read data.
    // Address register plus output register.
    localparam  int     READ_LATENCY      = 2;

endpackage

`default_nettype wire

// File: hdl/pattern_source_top.sv
`default_nettype none

module pattern_source_top #(
    parameter   int     X_BITS      = pattern_pkg::X_BITS_DEFAULT,
    parameter   int     Y_BITS      = pattern_pkg::Y_BITS_DEFAULT,
    parameter   int     DATA_BITS   = pattern_pkg::DATA_BITS_DEFAULT,
    parameter   int     TILE_BITS   = pattern_pkg::TILE_BITS_DEFAULT,
    parameter   int     INIT_WIDTH  = 640,
    parameter   int     INIT_HEIGHT = 480
) (
    input   var logic                       m_axi4s         ,
    input   var logic                       rst_n           ,

    // Host size port.
    input   var logic   [X_BITS-1:0]        cfg_width       ,
    input   var logic   [Y_BITS-1:0]        cfg_height      ,
    input   var logic                       cfg_load        ,
    output  var logic                       cfg_pending     ,

    // Host tile write port.
    input   var logic                       wr_en           ,
    input   var logic   [2*TILE_BITS-1:0]   wr_addr         ,
    input   var logic   [DATA_BITS-1:0]     wr_data         ,

    // AXI4-Stream master.
    output  var logic   [DATA_BITS-1:0]     m_axi4s_tdata   ,
    output  var logic                       m_axi4s_tvalid  ,
    output  var logic                       m_axi4s_tuser   ,
    output  var logic                       m_axi4s_tlast   ,
    input   var logic                       m_axi4s_tready
);

    logic                   rd_en;
    logic   [X_BITS-1:0]    rd_x;
    logic   [Y_BITS-1:0]    rd_y;
    logic                   frame_wrap;
    logic   [X_BITS-1:0]    active_width;
    logic   [Y_BITS-1:0]    active_height;

    // **************************************************
    //  Frame size shadow
    // **************************************************

    size_shadow #(
        .X_BITS         (X_BITS),
        .Y_BITS         (Y_BITS),
        .INIT_WIDTH     (INIT_WIDTH),
        .INIT_HEIGHT    (INIT_HEIGHT)
    ) u_size_shadow (
        .m_axi4s        (m_axi4s),
        .rst_n          (rst_n),
        .cfg_width      (cfg_width),
        .cfg_height     (cfg_height),
        .cfg_load       (cfg_load),
        .cfg_pending    (cfg_pending),
        .frame_wrap     (frame_wrap),
        .active_width   (active_width),
        .active_height  (active_height)
    );

    // **************************************************
    //  Raster scanner
    // **************************************************

    frame_scan #(
        .X_BITS         (X_BITS),
        .Y_BITS         (Y_BITS)
    ) u_frame_scan (
        .m_axi4s        (m_axi4s),
        .rst_n          (rst_n),
        .m_axi4s_tready (m_axi4s_tready),
        .active_width   (active_width),
        .active_height  (active_height),
        .rd_en          (rd_en),
        .rd_x           (rd_x),
        .rd_y           (rd_y),
        .frame_wrap     (frame_wrap),
        .m_axi4s_tvalid (m_axi4s_tvalid),
        .m_axi4s_tuser  (m_axi4s_tuser),
        .m_axi4s_tlast  (m_axi4s_tlast)
    );

    // **************************************************
    //  Tile memory
    // **************************************************

    // Low coordinate bits only, so the tile repeats across the frame.
    tile_ram #(
        .TILE_BITS      (TILE_BITS),
        .DATA_BITS      (DATA_BITS)
    ) u_tile_ram (
        .m_axi4s        (m_axi4s),
        .rst_n          (rst_n),
        .rd_en          (rd_en),
        .rd_x           (rd_x[TILE_BITS-1:0]),
        .rd_y           (rd_y[TILE_BITS-1:0]),
        .rd_data        (m_axi4s_tdata),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

endmodule

`default_nettype wire

// File: hdl/size_shadow.sv
`default_nettype none

module size_shadow #(
    parameter   int     X_BITS      = pattern_pkg::X_BITS_DEFAULT,
    parameter   int     Y_BITS      = pattern_pkg::Y_BITS_DEFAULT,
    parameter   int     INIT_WIDTH  = 640,
    parameter   int     INIT_HEIGHT = 480
) (
    input   var logic                   m_axi4s         ,
    input   var logic                   rst_n           ,

    input   var logic   [X_BITS-1:0]    cfg_width       ,
    input   var logic   [Y_BITS-1:0]    cfg_height      ,
    input   var logic                   cfg_load        ,
    output  var logic                   cfg_pending     ,

    input   var logic                   frame_wrap      ,
    output  var logic   [X_BITS-1:0]    active_width    ,
    output  var logic   [Y_BITS-1:0]    active_height
);

    // **************************************************
    //  Pending size
    // **************************************************

    logic   [X_BITS-1:0]    pend_width;
    logic   [Y_BITS-1:0]    pend_height;
    logic                   apply;

    // Swap only at the frame boundary.
    assign apply = frame_wrap && cfg_pending;

    always_ff @(posedge m_axi4s) begin
        if (cfg_load) begin
            pend_width  <= cfg_width;
            pend_height <= cfg_height;
        end
    end

    // A load on the swap edge stays pending for the next wrap.
    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            cfg_pending <= 1'b0;
        end else if (cfg_load) begin
            cfg_pending <= 1'b1;
        end else if (apply) begin
            cfg_pending <= 1'b0;
        end
    end

    // **************************************************
    //  Active size
    // **************************************************

    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            active_width  <= X_BITS'(INIT_WIDTH);
            active_height <= Y_BITS'(INIT_HEIGHT);
        end else if (apply) begin
            active_width  <= pend_width;     // Older request, not this edge's load.
            active_height <= pend_height;
        end
    end

endmodule

`default_nettype wire

// File: hdl/tile_ram.sv
`default_nettype none

module tile_ram #(
    parameter   int     TILE_BITS = pattern_pkg::TILE_BITS_DEFAULT,
    parameter   int     DATA_BITS = pattern_pkg::DATA_BITS_DEFAULT
) (
    input   var logic                       m_axi4s ,
    input   var logic                       rst_n   ,

    input   var logic                       rd_en   ,
    input   var logic   [TILE_BITS-1:0]     rd_x    ,
    input   var logic   [TILE_BITS-1:0]     rd_y    ,
    output  var logic   [DATA_BITS-1:0]     rd_data ,

    input   var logic                       wr_en   ,
    input   var logic   [2*TILE_BITS-1:0]   wr_addr ,
    input   var logic   [DATA_BITS-1:0]     wr_data
);

    localparam  int     LAT       = pattern_pkg::READ_LATENCY;
    localparam  int     ADDR_BITS = 2 * TILE_BITS;
    localparam  int     DEPTH     = 1 << ADDR_BITS;

    // **************************************************
    //  Storage, row major
    // **************************************************

    logic   [DATA_BITS-1:0]     mem [DEPTH];

    // Host write, independent of back-pressure.
    always_ff @(posedge m_axi4s) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // **************************************************
    //  Read path
    // **************************************************

    logic   [ADDR_BITS-1:0]     rd_addr;
    logic   [DATA_BITS-1:0]     dat_q   [LAT-1];

    // Address register.
    always_ff @(posedge m_axi4s) begin
        if (rd_en) begin
            rd_addr <= {rd_y, rd_x};
        end
    end

    // Array read sees the word before a write on the same edge.
    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT - 1; i++) begin
                dat_q[i] <= '0;
            end
        end else if (rd_en) begin
            dat_q[0] <= mem[rd_addr];
            for (int i = 1; i < LAT - 1; i++) begin
                dat_q[i] <= dat_q[i-1];
            end
        end
    end

    assign rd_data = dat_q[LAT-2];    // Last register stage.

endmodule

`default_nettype wire

// File: vlog.f
hdl/pattern_pkg.sv
hdl/size_shadow.sv
hdl/frame_scan.sv
hdl/tile_ram.sv
hdl/pattern_source_top.sv
bench/tb_pattern_source.sv
